// ==== compile.f ====
hw/clear_sync_pkg.sv
hw/clear_initiator.sv
hw/clear_phase_tx.sv
hw/clear_phase_rx.sv
hw/clear_receiver.sv
hw/clear_sync.sv
tests/tb_clear_sync.sv

// ==== hw/clear_initiator.sv ====
`timescale 1ns/1ps

// ---------------------------------------------------------------------------
// initiator of a clear sequence on one side
// ---------------------------------------------------------------------------

module clear_initiator (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  logic                         isolate_ack_i,
  input  logic                         clear_ack_i,
  input  logic                         phase_ready_i,
  output logic                         phase_valid_o,
  output clear_sync_pkg::clear_phase_e phase_o,
  output logic                         isolate_o,
  output logic                         clear_o
);
  import clear_sync_pkg::*;

  // the isolate and clear phases each have two wait states, because the
  // local ack and the remote phase handshake can finish in either order
  typedef enum logic [3:0] {
    INIT_IDLE,
    INIT_ISOLATE,
    INIT_WAIT_ISOLATE_ACK,
    INIT_WAIT_ISOLATE_PHASE,
    INIT_CLEAR,
    INIT_WAIT_CLEAR_ACK,
    INIT_WAIT_CLEAR_PHASE,
    INIT_POST_CLEAR,
    INIT_FINISHED
  } init_state_e;

  init_state_e state_d, state_q;

  always_comb begin
    state_d       = state_q;
    phase_valid_o = 1'b0;
    phase_o       = CLEAR_PHASE_IDLE;
    isolate_o     = 1'b0;
    clear_o       = 1'b0;

    case (state_q)
      // clear_i is only looked at here, so a pulse during a running
      // sequence is dropped
      INIT_IDLE: begin
        if (clear_i) begin
          state_d = INIT_ISOLATE;
        end
      end

      INIT_ISOLATE: begin
        phase_valid_o = 1'b1;
        phase_o       = CLEAR_PHASE_ISOLATE;
        isolate_o     = 1'b1;
        if (phase_ready_i && isolate_ack_i) begin
          state_d = INIT_CLEAR;
        end else if (phase_ready_i) begin
          state_d = INIT_WAIT_ISOLATE_ACK;
        end else if (isolate_ack_i) begin
          state_d = INIT_WAIT_ISOLATE_PHASE;
        end
      end

      // remote side already isolated, only the local ack is missing
      INIT_WAIT_ISOLATE_ACK: begin
        isolate_o = 1'b1;
        if (isolate_ack_i) begin
          state_d = INIT_CLEAR;
        end
      end

      // local side isolated, the phase is still on its way over
      INIT_WAIT_ISOLATE_PHASE: begin
        phase_valid_o = 1'b1;
        phase_o       = CLEAR_PHASE_ISOLATE;
        isolate_o     = 1'b1;
        if (phase_ready_i) begin
          state_d = INIT_CLEAR;
        end
      end

      INIT_CLEAR: begin
        phase_valid_o = 1'b1;
        phase_o       = CLEAR_PHASE_CLEAR;
        isolate_o     = 1'b1;
        clear_o       = 1'b1;
        if (phase_ready_i && clear_ack_i) begin
          state_d = INIT_POST_CLEAR;
        end else if (phase_ready_i) begin
          state_d = INIT_WAIT_CLEAR_ACK;
        end else if (clear_ack_i) begin
          state_d = INIT_WAIT_CLEAR_PHASE;
        end
      end

      INIT_WAIT_CLEAR_ACK: begin
        isolate_o = 1'b1;
        clear_o   = 1'b1;
        if (clear_ack_i) begin
          state_d = INIT_POST_CLEAR;
        end
      end

      INIT_WAIT_CLEAR_PHASE: begin
        phase_valid_o = 1'b1;
        phase_o       = CLEAR_PHASE_CLEAR;
        isolate_o     = 1'b1;
        clear_o       = 1'b1;
        if (phase_ready_i) begin
          state_d = INIT_POST_CLEAR;
        end
      end

      // clear drops here while isolate is held for the rest of the sequence
      INIT_POST_CLEAR: begin
        phase_valid_o = 1'b1;
        phase_o       = CLEAR_PHASE_POST_CLEAR;
        isolate_o     = 1'b1;
        if (phase_ready_i) begin
          state_d = INIT_FINISHED;
        end
      end

      // isolate only falls once the remote side has taken the idle phase
      INIT_FINISHED: begin
        phase_valid_o = 1'b1;
        phase_o       = CLEAR_PHASE_IDLE;
        isolate_o     = 1'b1;
        if (phase_ready_i) begin
          state_d = INIT_IDLE;
        end
      end

      default: begin
        state_d = INIT_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= INIT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // isolate covers every cycle of clear and outlasts it by at least a cycle
  a_clear_inside_isolate : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    clear_o |-> isolate_o ##1 isolate_o
  );

endmodule

// ==== hw/clear_phase_rx.sv ====
`timescale 1ns/1ps

// ---------------------------------------------------------------------------
// receiving half of the four-phase phase link
// ---------------------------------------------------------------------------

module clear_phase_rx #(
  parameter int unsigned SyncStages = clear_sync_pkg::DefaultSyncStages
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         async_req_i,
  input  clear_sync_pkg::clear_phase_e async_phase_i,
  output logic                         async_ack_o,
  output logic                         phase_valid_o,
  output clear_sync_pkg::clear_phase_e phase_o,
  input  logic                         phase_accept_i
);
  import clear_sync_pkg::*;

  logic [SyncStages-1:0] req_sync_q;
  logic                  req_seen;
  logic                  valid_q;
  logic                  ack_q;
  logic                  load;
  logic                  take;
  clear_phase_e          phase_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_sync_q <= '0;
    end else begin
      req_sync_q[0] <= async_req_i;
      for (int i = 1; i < SyncStages; i++) begin
        req_sync_q[i] <= req_sync_q[i-1];
      end
    end
  end

  assign req_seen = req_sync_q[SyncStages-1];

  // a new word is loaded once per request, ack_q blocks a second load
  // until the sender has dropped req
  assign load = req_seen && !valid_q && !ack_q;
  assign take = valid_q && phase_accept_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      ack_q   <= 1'b0;
    end else begin
      if (load) begin
        valid_q <= 1'b1;
      end else if (take) begin
        valid_q <= 1'b0;
      end
      // ack rises on accept and falls once the synchronized req is gone
      if (take) begin
        ack_q <= 1'b1;
      end else if (!req_seen) begin
        ack_q <= 1'b0;
      end
    end
  end

  // the word has been stable for SyncStages cycles by the time req is seen
  always_ff @(posedge clk_i) begin
    if (load) begin
      phase_q <= async_phase_i;
    end
  end

  assign async_ack_o   = ack_q;
  assign phase_valid_o = valid_q;
  assign phase_o       = phase_q;

endmodule

// ==== hw/clear_phase_tx.sv ====
`timescale 1ns/1ps

// ---------------------------------------------------------------------------
// sending half of the four-phase phase link
// ---------------------------------------------------------------------------

module clear_phase_tx #(
  parameter int unsigned SyncStages = clear_sync_pkg::DefaultSyncStages
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         phase_valid_i,
  input  clear_sync_pkg::clear_phase_e phase_i,
  output logic                         phase_ready_o,
  output logic                         async_req_o,
  output clear_sync_pkg::clear_phase_e async_phase_o,
  input  logic                         async_ack_i
);
  import clear_sync_pkg::*;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_REQ,
    TX_RELEASE
  } tx_state_e;

  tx_state_e             state_q;
  logic                  req_q;
  logic [SyncStages-1:0] ack_sync_q;
  logic                  ack_seen;
  logic                  load;
  clear_phase_e          phase_q;

  // the ack comes from the far side and goes through a plain flop chain
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_sync_q <= '0;
    end else begin
      ack_sync_q[0] <= async_ack_i;
      for (int i = 1; i < SyncStages; i++) begin
        ack_sync_q[i] <= ack_sync_q[i-1];
      end
    end
  end

  assign ack_seen = ack_sync_q[SyncStages-1];
  assign load     = (state_q == TX_IDLE) && phase_valid_i;

  // req has its own flop so that the crossing never sees a state decode
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= TX_IDLE;
      req_q   <= 1'b0;
    end else begin
      case (state_q)
        TX_IDLE: begin
          if (phase_valid_i) begin
            state_q <= TX_REQ;
            req_q   <= 1'b1;
          end
        end
        TX_REQ: begin
          if (ack_seen) begin
            state_q <= TX_RELEASE;
            req_q   <= 1'b0;
          end
        end
        TX_RELEASE: begin
          if (!ack_seen) begin
            state_q <= TX_IDLE;
          end
        end
        default: begin
          state_q <= TX_IDLE;
          req_q   <= 1'b0;
        end
      endcase
    end
  end

  // phase word is captured together with the rising req
  always_ff @(posedge clk_i) begin
    if (load) begin
      phase_q <= phase_i;
    end
  end

  assign async_req_o   = req_q;
  assign async_phase_o = phase_q;

  // done only after the ack has fallen again, so no phase is left in flight
  assign phase_ready_o = (state_q == TX_RELEASE) && !ack_seen;

  // the far side samples the word at any time while req is high
  a_phase_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    async_req_o && $past(async_req_o) |-> $stable(async_phase_o)
  );

endmodule

// ==== hw/clear_receiver.sv ====
`timescale 1ns/1ps

// ---------------------------------------------------------------------------
// receiver that mirrors the phases of the remote initiator
// ---------------------------------------------------------------------------

module clear_receiver (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         phase_valid_i,
  input  clear_sync_pkg::clear_phase_e phase_i,
  output logic                         phase_accept_o,
  input  logic                         isolate_ack_i,
  input  logic                         clear_ack_i,
  output logic                         isolate_o,
  output logic                         clear_o
);
  import clear_sync_pkg::*;

  // last phase that was accepted from the remote side
  clear_phase_e phase_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= CLEAR_PHASE_IDLE;
    end else if (phase_valid_i && phase_accept_o) begin
      phase_q <= phase_i;
    end
  end

  always_comb begin
    isolate_o      = 1'b0;
    clear_o        = 1'b0;
    phase_accept_o = 1'b0;

    if (phase_valid_i) begin
      // a pending phase drives the outputs at once, the accept waits for
      // the local side to confirm where that is needed
      case (phase_i)
        CLEAR_PHASE_IDLE: begin
          phase_accept_o = 1'b1;
        end
        CLEAR_PHASE_ISOLATE: begin
          isolate_o      = 1'b1;
          phase_accept_o = isolate_ack_i;
        end
        CLEAR_PHASE_CLEAR: begin
          isolate_o      = 1'b1;
          clear_o        = 1'b1;
          phase_accept_o = clear_ack_i;
        end
        CLEAR_PHASE_POST_CLEAR: begin
          isolate_o      = 1'b1;
          phase_accept_o = 1'b1;
        end
        default: begin
          phase_accept_o = 1'b0;
        end
      endcase
    end else begin
      // nothing offered, hold the levels of the last accepted phase
      case (phase_q)
        CLEAR_PHASE_ISOLATE: begin
          isolate_o = 1'b1;
        end
        CLEAR_PHASE_CLEAR: begin
          isolate_o = 1'b1;
          clear_o   = 1'b1;
        end
        CLEAR_PHASE_POST_CLEAR: begin
          isolate_o = 1'b1;
        end
        default: begin
          isolate_o = 1'b0;
        end
      endcase
    end
  end

endmodule

// ==== hw/clear_sync.sv ====
`timescale 1ns/1ps

// ---------------------------------------------------------------------------
// clear sequencer for both sides of a crossing
// ---------------------------------------------------------------------------

module clear_sync #(
  parameter int unsigned SyncStages = clear_sync_pkg::DefaultSyncStages
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic a_clear_i,
  input  logic a_isolate_ack_i,
  input  logic a_clear_ack_i,
  output logic a_isolate_o,
  output logic a_clear_o,
  input  logic b_clear_i,
  input  logic b_isolate_ack_i,
  input  logic b_clear_ack_i,
  output logic b_isolate_o,
  output logic b_clear_o
);
  import clear_sync_pkg::*;

  // side-local wiring between initiator and transmitter
  logic         a_init_valid, a_init_ready, a_init_isolate, a_init_clear;
  logic         b_init_valid, b_init_ready, b_init_isolate, b_init_clear;
  clear_phase_e a_init_phase, b_init_phase;

  // side-local wiring between receiving link half and receiver
  logic         a_rcv_valid, a_rcv_accept, a_rcv_isolate, a_rcv_clear;
  logic         b_rcv_valid, b_rcv_accept, b_rcv_isolate, b_rcv_clear;
  clear_phase_e a_rcv_phase, b_rcv_phase;

  // the crossing itself, one four-phase link in each direction
  logic         a2b_req, b2a_ack, b2a_req, a2b_ack;
  clear_phase_e a2b_phase, b2a_phase;

  // ---------------------------------------------------------------------------
  // side a
  // ---------------------------------------------------------------------------

  clear_initiator i_a_init (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (a_clear_i),
    .isolate_ack_i (a_isolate_ack_i),
    .clear_ack_i   (a_clear_ack_i),
    .phase_ready_i (a_init_ready),
    .phase_valid_o (a_init_valid),
    .phase_o       (a_init_phase),
    .isolate_o     (a_init_isolate),
    .clear_o       (a_init_clear)
  );

  clear_phase_tx #(.SyncStages(SyncStages)) i_a_tx (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .phase_valid_i (a_init_valid),
    .phase_i       (a_init_phase),
    .phase_ready_o (a_init_ready),
    .async_req_o   (a2b_req),
    .async_phase_o (a2b_phase),
    .async_ack_i   (b2a_ack)
  );

  // takes the phases that side b sends over
  clear_phase_rx #(.SyncStages(SyncStages)) i_a_rx (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .async_req_i    (b2a_req),
    .async_phase_i  (b2a_phase),
    .async_ack_o    (a2b_ack),
    .phase_valid_o  (a_rcv_valid),
    .phase_o        (a_rcv_phase),
    .phase_accept_i (a_rcv_accept)
  );

  clear_receiver i_a_rcv (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .phase_valid_i  (a_rcv_valid),
    .phase_i        (a_rcv_phase),
    .phase_accept_o (a_rcv_accept),
    .isolate_ack_i  (a_isolate_ack_i),
    .clear_ack_i    (a_clear_ack_i),
    .isolate_o      (a_rcv_isolate),
    .clear_o        (a_rcv_clear)
  );

  // ---------------------------------------------------------------------------
  // side b, the mirror of side a
  // ---------------------------------------------------------------------------

  clear_initiator i_b_init (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (b_clear_i),
    .isolate_ack_i (b_isolate_ack_i),
    .clear_ack_i   (b_clear_ack_i),
    .phase_ready_i (b_init_ready),
    .phase_valid_o (b_init_valid),
    .phase_o       (b_init_phase),
    .isolate_o     (b_init_isolate),
    .clear_o       (b_init_clear)
  );

  clear_phase_tx #(.SyncStages(SyncStages)) i_b_tx (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .phase_valid_i (b_init_valid),
    .phase_i       (b_init_phase),
    .phase_ready_o (b_init_ready),
    .async_req_o   (b2a_req),
    .async_phase_o (b2a_phase),
    .async_ack_i   (a2b_ack)
  );

  clear_phase_rx #(.SyncStages(SyncStages)) i_b_rx (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .async_req_i    (a2b_req),
    .async_phase_i  (a2b_phase),
    .async_ack_o    (b2a_ack),
    .phase_valid_o  (b_rcv_valid),
    .phase_o        (b_rcv_phase),
    .phase_accept_i (b_rcv_accept)
  );

  clear_receiver i_b_rcv (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .phase_valid_i  (b_rcv_valid),
    .phase_i        (b_rcv_phase),
    .phase_accept_o (b_rcv_accept),
    .isolate_ack_i  (b_isolate_ack_i),
    .clear_ack_i    (b_clear_ack_i),
    .isolate_o      (b_rcv_isolate),
    .clear_o        (b_rcv_clear)
  );

  // either source may own the outputs, so two sequences started at the
  // same time still give one clean isolate and clear envelope per side
  assign a_isolate_o = a_init_isolate | a_rcv_isolate;
  assign a_clear_o   = a_init_clear | a_rcv_clear;
  assign b_isolate_o = b_init_isolate | b_rcv_isolate;
  assign b_clear_o   = b_init_clear | b_rcv_clear;

endmodule

// ==== hw/clear_sync_pkg.sv ====
// ---------------------------------------------------------------------------
// shared definitions of the clear sequencer
// ---------------------------------------------------------------------------

package clear_sync_pkg;

  // phase of a clear sequence as it travels between the two sides
  // the order follows the sequence itself and ends back in idle
  typedef enum logic [1:0] {
    // isolate and clear both low, normal operation
    CLEAR_PHASE_IDLE       = 2'd0,
    // isolate high, the side has to stop all traffic and acknowledge
    CLEAR_PHASE_ISOLATE    = 2'd1,
    // isolate and clear high, the side wipes its state and acknowledges
    CLEAR_PHASE_CLEAR      = 2'd2,
    // clear low again while isolate stays high for one more phase
    CLEAR_PHASE_POST_CLEAR = 2'd3
  } clear_phase_e;

  // number of synchronizer flip-flops on each direction of the phase link
  // two is the usual choice for metastability settling, more only adds latency
  parameter int unsigned DefaultSyncStages = 2;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# builds the clear sequencer testbench with Verilator and runs it once
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_clear_sync \
  -f compile.f > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_clear_sync > sim.log 2>&1 || true
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log && exit 0 || exit 1

// ==== tests/tb_clear_sync.sv ====
`timescale 1ns/1ps

module tb_clear_sync;
  import clear_sync_pkg::*;

  localparam int NumRows   = 8;
  localparam int MaxDly    = 12;
  localparam int MaxJitter = 3;

  // one row of the scenario table, a cycle of -1 means no clear there
  // again re-pulses every side that cleared, while its sequence still runs
  typedef struct packed {
    int a_cyc;
    int b_cyc;
    int a_dly;
    int b_dly;
    int a_pulses;
    int b_pulses;
    int exact;
    int again;
  } row_t;

  logic       clk_i;
  logic       rst_ni;
  logic [1:0] clear_in;
  logic [1:0] iso_ack;
  logic [1:0] clr_ack;
  wire  [1:0] iso_out;
  wire  [1:0] clr_out;

  integer     seed;
  int         cycle_cnt = 0;
  int         cycle_limit;
  int         err_cnt;
  int         row_bound;
  logic       quiet_check;
  logic [1:0] clr_prev;
  int         dly [2];
  int         iso_cnt [2];
  int         clr_cnt [2];
  int         iso_jit [2];
  int         clr_jit [2];
  int         pulses [2];
  int         iso_len [2];

  // index 0 of every vector is side a, index 1 is side b
  clear_sync i_dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .a_clear_i       (clear_in[0]),
    .a_isolate_ack_i (iso_ack[0]),
    .a_clear_ack_i   (clr_ack[0]),
    .a_isolate_o     (iso_out[0]),
    .a_clear_o       (clr_out[0]),
    .b_clear_i       (clear_in[1]),
    .b_isolate_ack_i (iso_ack[1]),
    .b_clear_ack_i   (clr_ack[1]),
    .b_isolate_o     (iso_out[1]),
    .b_clear_o       (clr_out[1])
  );

  always #50 clk_i = ~clk_i;

  // ---------------------------------------------------------------------------
  // scenario table and helpers
  // ---------------------------------------------------------------------------

  function automatic row_t row_at(input int idx);
    case (idx)
      0: row_at = '{0, -1, 0, 0, 1, 1, 1, -1};
      1: row_at = '{-1, 0, 1, 1, 1, 1, 1, -1};
      2: row_at = '{0, 0, 0, 0, 1, 1, 0, -1};
      3: row_at = '{0, 3, 2, 1, 1, 1, 0, -1};
      4: row_at = '{2, 0, 0, 3, 1, 1, 0, -1};
      // slow b acks, a is cleared again while its isolate is high
      5: row_at = '{0, -1, 0, MaxDly, 1, 1, 1, 6};
      6: row_at = '{-1, 0, MaxDly, 2, 1, 1, 1, 5};
      default: row_at = '{0, 5, 8, 8, 1, 1, 0, -1};
    endcase
  endfunction

  function automatic int max2(input int x, input int y);
    max2 = (x > y) ? x : y;
  endfunction

  // four phases, each a full link handshake plus the ack wait, and some slack
  function automatic int seq_bound(input int d);
    seq_bound = 4 * (4 * DefaultSyncStages + 4 + d) + 8;
  endfunction

  function automatic int draw_jitter();
    draw_jitter = $unsigned($random(seed)) % (MaxJitter + 1);
  endfunction

  task automatic compare(input int actual, input int expected, input string what);
    if (actual != expected) begin
      err_cnt++;
      $display("ERR %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
      $display("Verification failed");
      $fatal(1, "stopped at the first error");
    end
  endtask

  // all levels low for a few cycles in a row means both sides are idle again
  task automatic wait_quiet();
    int calm;
    calm = 0;
    while (calm < 4) begin
      @(posedge clk_i);
      #30;
      if (iso_out == 2'b00 && clr_out == 2'b00 && iso_ack == 2'b00 && clr_ack == 2'b00) begin
        calm++;
      end else begin
        calm = 0;
      end
    end
  endtask

  // ---------------------------------------------------------------------------
  // ack models
  // ---------------------------------------------------------------------------

  // each ack follows its output level after the row delay plus a random jitter,
  // a level that flips back before the ack caught up restarts the count
  always @(posedge clk_i) begin
    bit sd;
    #10;
    for (int s = 0; s < 2; s++) begin
      sd = 1'(s);
      if (iso_out[sd] != iso_ack[sd]) begin
        if (iso_cnt[sd] >= dly[sd] + iso_jit[sd]) begin
          iso_ack[sd] = iso_out[sd];
          iso_cnt[sd] = 0;
          iso_jit[sd] = draw_jitter();
        end else begin
          iso_cnt[sd]++;
        end
      end else begin
        iso_cnt[sd] = 0;
      end
      if (clr_out[sd] != clr_ack[sd]) begin
        if (clr_cnt[sd] >= dly[sd] + clr_jit[sd]) begin
          clr_ack[sd] = clr_out[sd];
          clr_cnt[sd] = 0;
          clr_jit[sd] = draw_jitter();
        end else begin
          clr_cnt[sd]++;
        end
      end else begin
        clr_cnt[sd] = 0;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // ordering checks, sampled mid-cycle where every level has settled
  // ---------------------------------------------------------------------------

  always @(negedge clk_i) begin
    bit    sd;
    string side;
    if (rst_ni) begin
      for (int s = 0; s < 2; s++) begin
        sd   = 1'(s);
        side = (s == 0) ? "a" : "b";
        if (quiet_check) begin
          compare(int'(iso_out[sd]), 0, $sformatf("%s isolate high before any clear", side));
          compare(int'(clr_out[sd]), 0, $sformatf("%s clear high before any clear", side));
        end
        compare(int'(clr_out[sd] && !iso_out[sd]), 0,
                $sformatf("%s clear high while its isolate is low", side));
        // a rising clear needs the local isolate ack and an isolated far side
        if (clr_out[sd] && !clr_prev[sd]) begin
          pulses[sd]++;
          compare(int'(iso_ack[sd]), 1, $sformatf("%s clear rose before its isolate ack", side));
          compare(int'(iso_out[~sd]), 1,
                  $sformatf("%s clear rose before the far side isolated", side));
          compare(int'(iso_ack[~sd]), 1,
                  $sformatf("%s clear rose before the far side isolate ack", side));
        end
        if (iso_out[sd]) begin
          iso_len[sd]++;
          compare(int'(iso_len[sd] <= row_bound), 1,
                  $sformatf("%s isolate stayed high past the sequence bound", side));
        end else begin
          iso_len[sd] = 0;
        end
      end
      clr_prev = clr_out;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("the run did not finish within %0d cycles", cycle_limit);
      $display("Verification failed");
      $fatal(1, "timeout");
    end
  end

  // ---------------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------------

  initial begin
    row_t r;
    int   last;
    seed        = 32'hc4a7;
    err_cnt     = 0;
    cycle_limit = NumRows * seq_bound(MaxDly + MaxJitter + 1) + 200;
    row_bound   = seq_bound(0);
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    clear_in    = '0;
    iso_ack     = '0;
    clr_ack     = '0;
    clr_prev    = '0;
    quiet_check = 1'b0;
    for (int s = 0; s < 2; s++) begin
      dly[s]     = 0;
      iso_cnt[s] = 0;
      clr_cnt[s] = 0;
      iso_jit[s] = 0;
      clr_jit[s] = 0;
      pulses[s]  = 0;
      iso_len[s] = 0;
    end

    repeat (16) @(posedge clk_i);
    #10;
    rst_ni      = 1'b1;
    quiet_check = 1'b1;
    repeat (20) begin
      @(posedge clk_i);
      #30;
    end
    quiet_check = 1'b0;

    for (int i = 0; i < NumRows; i++) begin
      r         = row_at(i);
      dly[0]    = r.a_dly;
      dly[1]    = r.b_dly;
      last      = max2(max2(r.a_cyc, r.b_cyc), r.again);
      row_bound = seq_bound(max2(r.a_dly, r.b_dly) + MaxJitter + 1) + last;
      pulses[0] = 0;
      pulses[1] = 0;
      @(posedge clk_i);
      #10;
      for (int k = 0; k <= last; k++) begin
        clear_in[0] = (k == r.a_cyc) || (k == r.again && r.a_cyc >= 0);
        clear_in[1] = (k == r.b_cyc) || (k == r.again && r.b_cyc >= 0);
        @(posedge clk_i);
        #10;
      end
      clear_in = '0;
      wait_quiet();
      if (r.exact != 0) begin
        compare(pulses[0], r.a_pulses, "clear pulses on side a");
        compare(pulses[1], r.b_pulses, "clear pulses on side b");
      end else begin
        compare(int'(pulses[0] >= r.a_pulses), 1, "too few clear pulses on side a");
        compare(int'(pulses[1] >= r.b_pulses), 1, "too few clear pulses on side b");
      end
      $display("row %0d done, clear pulses a %0d b %0d", i, pulses[0], pulses[1]);
    end

    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
